/* filelist.f */
source/histGeomPkg.sv
source/histCtrlPkg.sv
source/histRamIf.sv
source/histRam.sv
source/histSequencer.sv
source/peakFinder.sv
source/histTop.sv
tests/histSeq_chk.sv
tests/histTb.sv

/* tests/histTb.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the one-pixel arrival-time histogram
module histTb;

    logic                              clk;
    logic                              res;
    logic                              wrEn;
    logic                              frameEnd;
    logic [histGeomPkg::binBits-1:0]   data;
    logic                              busy;
    logic                              peakValid;
    logic [histGeomPkg::binBits-1:0]   peakBin;
    logic [histGeomPkg::countBits-1:0] peakCount;

    int unsigned lcgState = 87160;
    int          refCount [histGeomPkg::numBins]; // expected count per bin

    histTop uut (
        .clk       (clk),
        .res       (res),
        .wrEn      (wrEn),
        .frameEnd  (frameEnd),
        .data      (data),
        .busy      (busy),
        .peakValid (peakValid),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    // next LCG value in 0 to range-1
    function automatic int nextRand(input int range);
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return int'((lcgState >> 8) % $unsigned(range));
    endfunction

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // a failed sequencer assertion ends the run at once
    always @(negedge clk) begin
        if (uut.uSeq.chk.errorCount != 0) begin
            abortRun("a sequencer protocol assertion failed");
        end
    end

    task automatic clearReference();
        int b;
        for (b = 0; b < histGeomPkg::numBins; b++) begin
            refCount[b] = 0;
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            wrEn     = 1'b0;
            frameEnd = 1'b0;
        end
    endtask

    // one accepted event counted in the reference with saturation
    task automatic sendEvent(input int bin);
        @(negedge clk);
        wrEn     = 1'b1;
        frameEnd = 1'b0;
        data     = histGeomPkg::binT'(bin);
        if (refCount[bin] < int'(histGeomPkg::countMax)) begin
            refCount[bin]++;
        end
    endtask

    // end the frame and check the report that follows
    task automatic finishFrame(input bit strobeBusy);
        int  b;
        int  expBin;
        int  expCount;
        int  waited;
        bit  seen;
        expBin   = 0;
        expCount = 0;
        for (b = 0; b < histGeomPkg::numBins; b++) begin
            if (refCount[b] > expCount) begin // lowest bin keeps a tie
                expBin   = b;
                expCount = refCount[b];
            end
        end
        @(negedge clk);
        wrEn     = 1'b0;
        frameEnd = 1'b1;
        @(negedge clk);
        frameEnd = 1'b0;
        waited   = 0;
        seen     = 1'b0;
        while (!seen && waited <= histCtrlPkg::scanLatency + 20) begin
            if (peakValid) begin
                seen = 1'b1;
            end else begin
                assert (busy) else abortRun($sformatf(
                    "mismatch at %0t: busy low %0d cycles after frameEnd", $time, waited));
                wrEn = strobeBusy; // dropped by the DUT and kept out of the reference
                data = histGeomPkg::binT'(nextRand(histGeomPkg::numBins));
                @(negedge clk);
                waited++;
            end
        end
        wrEn = 1'b0;
        if (!seen) begin
            abortRun("timeout: peakValid never came after frameEnd");
        end else begin
            assert (waited == histCtrlPkg::scanLatency) else abortRun($sformatf(
                "mismatch at %0t: peakValid after %0d cycles, expected %0d",
                $time, waited, histCtrlPkg::scanLatency));
            assert (!busy) else abortRun($sformatf(
                "mismatch at %0t: busy still high with peakValid", $time));
            assert (peakBin == expBin) else abortRun($sformatf(
                "mismatch at %0t: peakBin %0d, expected %0d", $time, peakBin, expBin));
            assert (peakCount == expCount) else abortRun($sformatf(
                "mismatch at %0t: peakCount %0d, expected %0d", $time, peakCount, expCount));
            @(negedge clk);
            assert (!peakValid) else abortRun($sformatf(
                "mismatch at %0t: peakValid longer than one cycle", $time));
            assert (peakBin == expBin && peakCount == expCount) else abortRun($sformatf(
                "mismatch at %0t: peak result did not hold", $time));
            clearReference(); // scan cleared the RAM
        end
    endtask

    initial begin
        int i;
        res      = 1'b0;
        wrEn     = 1'b0;
        frameEnd = 1'b0;
        data     = '0;
        clearReference();
        repeat (4) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
        idleCycles(2);

        finishFrame(1'b0); // empty frame reports bin 0 with count 0

        // random events with random gaps
        for (i = 0; i < 200; i++) begin
            sendEvent(nextRand(histGeomPkg::numBins));
            idleCycles(nextRand(4));
        end
        finishFrame(1'b0);

        // back-to-back burst on one bin
        for (i = 0; i < 23; i++) begin
            sendEvent(40);
        end
        finishFrame(1'b0);

        // alternating bins where the higher bin gets one more
        for (i = 0; i < 31; i++) begin
            sendEvent((i % 2 == 0) ? 13 : 12);
        end
        finishFrame(1'b0);

        // hits one and two events apart
        for (i = 0; i < 12; i++) begin
            sendEvent(9);
            sendEvent(9);
            sendEvent(30);
        end
        finishFrame(1'b0);

        // tie between bins 50 and 20
        for (i = 0; i < 7; i++) begin
            sendEvent(50);
            idleCycles(1);
            sendEvent(20);
            if (i < 4) begin
                sendEvent(3);
            end
        end
        finishFrame(1'b0);

        // saturation with events strobed while busy
        for (i = 0; i < 300; i++) begin
            sendEvent(33);
        end
        finishFrame(1'b1);

        // next frame must start from an empty histogram
        sendEvent(2);
        idleCycles(2);
        sendEvent(2);
        sendEvent(60);
        idleCycles(1);
        sendEvent(2);
        finishFrame(1'b1);

        for (i = 0; i < 100; i++) begin
            sendEvent(nextRand(histGeomPkg::numBins));
            idleCycles(nextRand(3));
        end
        finishFrame(1'b1);

        idleCycles(4);
        if (uut.uSeq.chk.errorCount == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("%0d sequencer protocol assertions failed", uut.uSeq.chk.errorCount);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* tests/histSeq_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the histogram sequencer
module histSeqChk (
    input logic                  clk,
    input logic                  res,
    input logic                  busy,
    input logic                  scanStart,
    input logic                  sampleValid,
    input logic                  scanDone,
    input logic                  wEnable,
    input logic                  rEnable,
    input logic                  wrValid,
    input histCtrlPkg::seqStateT state
);

    int errorCount = 0; // failed assertions so far
    int sampleTotal;    // samples since the last scanStart

    always_ff @(posedge clk) begin
        if (scanStart) begin
            sampleTotal <= 0;
        end else if (sampleValid) begin
            sampleTotal <= sampleTotal + 1;
        end
    end

    // both RAM ports idle right after reset
    resetIdle: assert property (@(posedge clk) $rose(res) |-> (!wEnable && !rEnable && !busy))
        else begin
            errorCount++;
            $error("RAM port active right after reset");
        end

    // scanDone drives peakValid so it must stay a single cycle
    doneOnce: assert property (@(posedge clk) disable iff (!res) scanDone |=> !scanDone)
        else begin
            errorCount++;
            $error("scanDone held longer than one cycle");
        end

    // drain is over before the scan, so no event write may land in it
    noEventWriteInScan: assert property (@(posedge clk) disable iff (!res)
        (state == histCtrlPkg::scan || state == histCtrlPkg::report) |-> !wrValid)
        else begin
            errorCount++;
            $error("event write during scan or report");
        end

    scanLength: assert property (@(posedge clk) disable iff (!res)
        scanStart |-> ##(histGeomPkg::numBins + 1) scanDone)
        else begin
            errorCount++;
            $error("scanDone not numBins samples after scanStart");
        end

    sampleNumber: assert property (@(posedge clk) disable iff (!res)
        scanDone |-> (sampleTotal == histGeomPkg::numBins))
        else begin
            errorCount++;
            $error("wrong number of scan samples");
        end

    busyWindow: assert property (@(posedge clk) disable iff (!res)
        $rose(busy) |-> ##(histCtrlPkg::scanLatency - 1) (busy && scanDone) ##1 !busy)
        else begin
            errorCount++;
            $error("busy window does not match the frame-end latency");
        end

endmodule

bind histSequencer histSeqChk chk (
    .clk         (clk),
    .res         (res),
    .busy        (busy),
    .scanStart   (scanStart),
    .sampleValid (sampleValid),
    .scanDone    (scanDone),
    .wEnable     (ram.wEnable),
    .rEnable     (ram.rEnable),
    .wrValid     (wrValid),
    .state       (state)
);

`default_nettype wire

/* source/histTop.sv */
`timescale 1ns/1ps
`default_nettype none

// one-pixel histogram: sequencer, dual-port RAM and peak finder
module histTop (
    input  logic                               clk,
    input  logic                               res,
    input  logic                               wrEn,
    input  logic                               frameEnd,
    input  logic [histGeomPkg::binBits-1:0]    data,
    output logic                               busy,
    output logic                               peakValid,
    output logic [histGeomPkg::binBits-1:0]    peakBin,
    output logic [histGeomPkg::countBits-1:0]  peakCount
);

    histRamIf ramBus ();

    // scan samples into the peak finder
    logic               scanStart;
    logic               sampleValid;
    logic               scanDone;
    histGeomPkg::binT   sampleBin;
    histGeomPkg::countT sampleCount;

    histRam uRam (
        .clk  (clk),
        .port (ramBus.mem)
    );

    histSequencer uSeq (
        .clk         (clk),
        .res         (res),
        .wrEn        (wrEn),
        .frameEnd    (frameEnd),
        .data        (data),
        .ram         (ramBus.ctrl),
        .busy        (busy),
        .scanStart   (scanStart),
        .sampleValid (sampleValid),
        .scanDone    (scanDone),
        .sampleBin   (sampleBin),
        .sampleCount (sampleCount)
    );

    peakFinder uPeak (
        .clk         (clk),
        .res         (res),
        .scanStart   (scanStart),
        .sampleValid (sampleValid),
        .scanDone    (scanDone),
        .sampleBin   (sampleBin),
        .sampleCount (sampleCount),
        .peakValid   (peakValid),
        .peakBin     (peakBin),
        .peakCount   (peakCount)
    );

endmodule

`default_nettype wire

/* source/peakFinder.sv */
`timescale 1ns/1ps
`default_nettype none

// largest count over one scan, lowest bin on ties
module peakFinder (
    input  logic               clk,
    input  logic               res,
    input  logic               scanStart,
    input  logic               sampleValid,
    input  logic               scanDone,
    input  histGeomPkg::binT   sampleBin,
    input  histGeomPkg::countT sampleCount,
    output logic               peakValid,
    output histGeomPkg::binT   peakBin,
    output histGeomPkg::countT peakCount
);

    histGeomPkg::binT   maxBin;
    histGeomPkg::countT maxCount;

    // running maximum, bins arrive in ascending order
    always_ff @(posedge clk) begin
        if (scanStart) begin
            maxBin   <= '0;
            maxCount <= '0; // all-zero frame reports bin 0
        end else if (sampleValid && (sampleCount > maxCount)) begin
            maxBin   <= sampleBin; // strict compare keeps the earlier bin
            maxCount <= sampleCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakValid <= 1'b0;
        end else begin
            peakValid <= scanDone; // one cycle, scanDone is a pulse
        end
    end

    // result holds until the next frame reports
    always_ff @(posedge clk) begin
        if (scanDone) begin
            peakBin   <= maxBin;
            peakCount <= maxCount;
        end
    end

endmodule

`default_nettype wire

/* source/histSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// event read-modify-write pipeline, then frame-end scan and clear
module histSequencer (
    input  logic               clk,
    input  logic               res,
    input  logic               wrEn,
    input  logic               frameEnd,
    input  histGeomPkg::binT   data,
    histRamIf.ctrl             ram,
    output logic               busy,
    output logic               scanStart,
    output logic               sampleValid,
    output logic               scanDone,
    output histGeomPkg::binT   sampleBin,
    output histGeomPkg::countT sampleCount
);

    histCtrlPkg::seqStateT state;
    histCtrlPkg::phaseT    phase;     // cycles since frameEnd

    // read stage, event latched from the input
    logic                  rdValid;
    histGeomPkg::binT      rdBin;

    // write stage, count comes back from the RAM here
    logic                  wrValid;
    histGeomPkg::binT      wrBin;
    logic                  fwdHit;    // previous write went to this bin
    histGeomPkg::countT    fwdCount;  // value of that write
    histGeomPkg::countT    oldCount;
    histGeomPkg::countT    newCount;

    // scan sample stage
    histGeomPkg::binT      scanAddr;
    logic                  smpValid;
    histGeomPkg::binT      smpBin;

    assign busy = (state != histCtrlPkg::collect);

    // address walks upward once the drain is over
    assign scanAddr = histGeomPkg::binT'(phase - histCtrlPkg::phaseT'(histCtrlPkg::drainCycles));

    assign scanStart = (state == histCtrlPkg::scan) &&
        (phase == histCtrlPkg::phaseT'(histCtrlPkg::drainCycles));
    assign scanDone = (state == histCtrlPkg::report) &&
        (phase == histCtrlPkg::phaseT'(histCtrlPkg::scanLatency - 1));

    // the RAM cannot return a write made on the same edge as the read,
    // so a back-to-back hit on one bin takes the in-flight value
    assign oldCount = fwdHit ? fwdCount : ram.rdata;
    assign newCount = (oldCount == histGeomPkg::countMax) ?
        histGeomPkg::countMax : oldCount + histGeomPkg::countT'(1); // saturate

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= histCtrlPkg::collect;
            phase    <= '0;
            rdValid  <= 1'b0;
            wrValid  <= 1'b0;
            fwdHit   <= 1'b0;
            smpValid <= 1'b0;
        end else begin
            rdValid  <= wrEn && !busy; // events while busy are dropped
            wrValid  <= rdValid;
            fwdHit   <= rdValid && wrValid && (rdBin == wrBin);
            smpValid <= (state == histCtrlPkg::scan);

            if (state == histCtrlPkg::collect) begin
                phase <= '0;
            end else begin
                phase <= phase + histCtrlPkg::phaseT'(1);
            end

            case (state)
                histCtrlPkg::collect: begin
                    if (frameEnd) begin
                        state <= histCtrlPkg::drain;
                    end
                end
                histCtrlPkg::drain: begin // last event write lands at the end
                    if (phase == histCtrlPkg::phaseT'(histCtrlPkg::drainCycles - 1)) begin
                        state <= histCtrlPkg::scan;
                    end
                end
                histCtrlPkg::scan: begin
                    if (phase == histCtrlPkg::phaseT'(histCtrlPkg::drainCycles +
                            histGeomPkg::numBins - 1)) begin
                        state <= histCtrlPkg::report;
                    end
                end
                histCtrlPkg::report: begin
                    if (scanDone) begin
                        state <= histCtrlPkg::collect;
                    end
                end
                default: state <= histCtrlPkg::collect;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rdBin    <= data;
        wrBin    <= rdBin;
        fwdCount <= newCount; // written value of the event now leaving
        smpBin   <= scanAddr;
    end

    // port B: event reads, or the scan
    assign ram.rEnable = rdValid || (state == histCtrlPkg::scan);
    assign ram.raddr   = (state == histCtrlPkg::scan) ? scanAddr : rdBin;

    // port A: event updates, or zero behind the scan, never both at once
    assign ram.wEnable = wrValid || smpValid;
    assign ram.waddr   = smpValid ? smpBin : wrBin;
    assign ram.wdata   = smpValid ? '0 : newCount;

    assign sampleValid = smpValid;
    assign sampleBin   = smpBin;
    assign sampleCount = ram.rdata;

endmodule

`default_nettype wire

/* source/histRam.sv */
`timescale 1ns/1ps
`default_nettype none

// one histogram of numBins counts, write port A, read port B
module histRam (
    input  logic       clk,
    histRamIf.mem      port
);

    histGeomPkg::countT mem [histGeomPkg::numBins];

    // histogram starts empty after configuration
    initial begin
        for (int i = 0; i < histGeomPkg::numBins; i++) begin
            mem[i] = '0;
        end
    end

    // port A, plain write
    always_ff @(posedge clk) begin
        if (port.wEnable) begin
            mem[port.waddr] <= port.wdata;
        end
    end

    // port B, registered read
    // a write to the same address on the same edge is not seen here,
    // the sequencer forwards around that case
    always_ff @(posedge clk) begin
        if (port.rEnable) begin
            port.rdata <= mem[port.raddr];
        end
    end

endmodule

`default_nettype wire

/* source/histRamIf.sv */
`timescale 1ns/1ps
`default_nettype none

// write port and registered read port of the histogram RAM
interface histRamIf;

    logic                wEnable;
    histGeomPkg::binT    waddr;
    histGeomPkg::countT  wdata;

    logic                rEnable;
    histGeomPkg::binT    raddr;
    histGeomPkg::countT  rdata; // valid the cycle after rEnable

    // sequencer side
    modport ctrl (
        output wEnable,
        output waddr,
        output wdata,
        output rEnable,
        output raddr,
        input  rdata
    );

    // memory side
    modport mem (
        input  wEnable,
        input  waddr,
        input  wdata,
        input  rEnable,
        input  raddr,
        output rdata
    );

endinterface

`default_nettype wire

/* source/histCtrlPkg.sv */
`default_nettype none

// sequencer control: states, drain depth and frame-end timing
package histCtrlPkg;

    typedef enum logic [1:0] {
        collect, // accepting events
        drain,   // letting in-flight updates land
        scan,    // reading out and clearing bins
        report   // last sample and peak hand-off
    } seqStateT;

    localparam int drainCycles = 2; // read stage plus write stage

    // frameEnd edge to peakValid edge
    localparam int scanLatency = drainCycles + histGeomPkg::numBins + 2;

    // cycle index since frameEnd, covers the whole drain, scan and report
    localparam int phaseBits = $clog2(scanLatency);
    typedef logic [phaseBits-1:0] phaseT;

endpackage

`default_nettype wire

/* source/histGeomPkg.sv */
`default_nettype none

// geometry of one pixel's arrival-time histogram
package histGeomPkg;

    // time-bin value, also the RAM address
    localparam int binBits = 6;

    // one RAM word per bin
    localparam int numBins = 2 ** binBits;

    // kept narrow so a frame can reach saturation
    localparam int countBits = 8;

    typedef logic [binBits-1:0] binT;
    typedef logic [countBits-1:0] countT;

    // counts stick here and never wrap
    localparam countT countMax = '1;

endpackage

`default_nettype wire
